// File: gnn_settings.svh
`ifndef GNN_SETTINGS_SVH
`define GNN_SETTINGS_SVH

// feature values per node with two on each beat.
`define FV_NUM 16

`define FV_WIDTH 16

`define NODE_ID_WIDTH 8

// beats the reservation station can hold.
`define RS_CREDITS 4

// beats the output buffer can hold.
`define OUT_CREDITS 2

`endif

// File: gnn_pkg.sv
`include "gnn_settings.svh"

package gnn_pkg;

    localparam int BEATS = `FV_NUM / 2;                     // beats in a full-length stream.
    localparam int IDX_W = (BEATS > 1) ? $clog2(BEATS) : 1;

    typedef logic [`FV_WIDTH-1:0]      fv_t;
    typedef logic [`NODE_ID_WIDTH-1:0] node_id_t;
    typedef logic [IDX_W-1:0]          beat_idx_t;

    // beat from the edge processing element.
    typedef struct packed {
        fv_t      val_hi;
        fv_t      val_lo;
        node_id_t node_id;
        logic     sos;
        logic     eos;
        logic     done_aggr;       // only looked at on the eos beat.
        logic     wb_en;
    } edge_beat_t;

    typedef struct packed {
        fv_t      val_hi;
        fv_t      val_lo;
        node_id_t node_id;
        logic     sos;
        logic     eos;
    } rs_beat_t;

    typedef struct packed {
        fv_t      val_hi;
        fv_t      val_lo;
        node_id_t node_id;
        logic     sos;
        logic     eos;
        logic     wb_tag;          // marks partial sums written back.
    } out_beat_t;

    typedef enum logic [2:0] {
        IDLE,
        STREAM_IN,
        DECIDE,
        DRAIN_RS,
        DRAIN_OUT
    } bank_state_t;

endpackage

// File: credit_sender.sv
`timescale 1ns/100ps

module credit_sender #(
    parameter type payload_t = logic [31:0],
    parameter int  CREDITS   = 2
) (
    input  logic     clk,
    input  logic     reset,
    input  logic     send,
    input  payload_t payload,
    input  logic     credit_in,
    output logic     has_credit,
    output logic     valid,
    output payload_t beat
);

    localparam int CW = $clog2(CREDITS + 1);

    logic [CW-1:0] credits;

    always_ff @(posedge clk) begin
        if (!reset) begin
            credits <= CW'(CREDITS);
            valid   <= 1'b0;
        end else begin
            valid   <= send;
            // credit is taken when the beat is registered.
            credits <= credits - CW'(send) + CW'(credit_in);
        end
    end

    always_ff @(posedge clk) begin
        if (send) begin
            beat <= payload;
        end
    end

    assign has_credit = (credits != '0);

    a_send_needs_credit: assert property (@(posedge clk) disable iff (!reset)
        send |-> has_credit);

    a_credit_bound: assert property (@(posedge clk) disable iff (!reset)
        credits <= CW'(CREDITS));

endmodule

// File: beat_counter.sv
`timescale 1ns/100ps

module beat_counter (
    input  logic               clk,
    input  logic               reset,
    input  logic               step,
    input  logic               clear,
    input  logic               load_len,
    output gnn_pkg::beat_idx_t idx,
    output logic               first_beat,
    output logic               last_beat
);
    import gnn_pkg::*;

    beat_idx_t len;                                         // index of the eos beat.

    always_ff @(posedge clk) begin
        if (!reset) begin
            idx <= '0;
            len <= beat_idx_t'(BEATS - 1);
        end else if (clear || load_len) begin
            idx <= '0;
            if (load_len) begin
                len <= idx;                                 // eos beat sits at the current index.
            end
        end else if (step) begin
            idx <= idx + 1'b1;
        end
    end

    assign first_beat = (idx == '0);
    assign last_beat  = (idx == len);

    // an input stream longer than the buffer would wrap the index.
    a_stream_fits: assert property (@(posedge clk) disable iff (!reset)
        (step && !clear && !load_len) |-> (idx != beat_idx_t'(BEATS - 1)));

endmodule

// File: feature_accum_buffer.sv
`timescale 1ns/100ps
`include "gnn_settings.svh"

module feature_accum_buffer (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 acc_en,
    input  logic                 clr,
    input  gnn_pkg::beat_idx_t   idx,
    input  logic [`FV_WIDTH-1:0] add_lo,
    input  logic [`FV_WIDTH-1:0] add_hi,
    output logic [`FV_WIDTH-1:0] sum_lo,
    output logic [`FV_WIDTH-1:0] sum_hi
);
    import gnn_pkg::*;

    fv_t [`FV_NUM-1:0] slot;
    logic [IDX_W:0]    lo_addr;
    logic [IDX_W:0]    hi_addr;

    assign lo_addr = {idx, 1'b0};
    assign hi_addr = {idx, 1'b1};

    // read port feeds both the add and the drain.
    assign sum_lo = slot[lo_addr];
    assign sum_hi = slot[hi_addr];

    always_ff @(posedge clk) begin
        if (!reset || clr) begin
            slot <= '0;
        end else if (acc_en) begin
            slot[lo_addr] <= sum_lo + add_lo;               // wraps at FV_WIDTH.
            slot[hi_addr] <= sum_hi + add_hi;
        end
    end

    // accumulation and clear belong to different phases of the controller.
    a_no_add_on_clear: assert property (@(posedge clk) disable iff (!reset)
        clr |-> !acc_en);

endmodule

// File: edge_bank_ctrl.sv
`timescale 1ns/100ps
`include "gnn_settings.svh"

module edge_bank_ctrl (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      in_valid,
    input  gnn_pkg::edge_beat_t       in_beat,
    output logic                      in_ready,
    input  logic                      last_beat,
    input  logic                      rs_has_credit,
    input  logic                      out_has_credit,
    output logic                      acc_en,
    output logic                      cnt_step,
    output logic                      cnt_clear,
    output logic                      buf_clr,
    output logic                      rs_send,
    output logic                      out_send,
    output logic [`NODE_ID_WIDTH-1:0] node_id
);
    import gnn_pkg::*;

    bank_state_t state;
    logic        cmd_rs;
    logic        cmd_out;
    logic        drain_end;

    always_comb begin
        in_ready  = (state == IDLE) || (state == STREAM_IN);
        acc_en    = in_valid && in_ready;
        rs_send   = (state == DRAIN_RS) && rs_has_credit;
        out_send  = (state == DRAIN_OUT) && out_has_credit;
        drain_end = (rs_send || out_send) && last_beat;     // eos beat is being registered.
        cnt_step  = acc_en || rs_send || out_send;
        cnt_clear = drain_end;
        buf_clr   = drain_end;
    end

    always_ff @(posedge clk) begin
        if (!reset) begin
            state   <= IDLE;
            cmd_rs  <= 1'b0;
            cmd_out <= 1'b0;
        end else begin
            case (state)
                IDLE, STREAM_IN: begin
                    if (acc_en) begin
                        state <= in_beat.eos ? DECIDE : STREAM_IN;
                    end
                end
                DECIDE: begin
                    if (cmd_rs) begin
                        state <= DRAIN_RS;
                    end else if (cmd_out) begin
                        state <= DRAIN_OUT;
                    end else begin
                        state <= IDLE;                      // keep sums for the next iteration.
                    end
                end
                DRAIN_RS, DRAIN_OUT: begin
                    if (drain_end) begin
                        state <= IDLE;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase

            if (acc_en && in_beat.eos) begin
                cmd_rs  <= in_beat.done_aggr;
                cmd_out <= in_beat.wb_en && !in_beat.done_aggr;   // done_aggr wins.
            end
        end
    end

    always_ff @(posedge clk) begin
        if (acc_en && in_beat.sos) begin
            node_id <= in_beat.node_id;
        end
    end

    a_idle_needs_sos: assert property (@(posedge clk) disable iff (!reset)
        (state == IDLE && in_valid) |-> in_beat.sos);

endmodule

// File: edge_bank_top.sv
`timescale 1ns/100ps
`include "gnn_settings.svh"

module edge_bank_top (
    input  logic                clk,
    input  logic                reset,
    input  logic                in_valid,
    input  gnn_pkg::edge_beat_t in_beat,
    output logic                in_ready,
    output logic                rs_valid,
    output gnn_pkg::rs_beat_t   rs_beat,
    input  logic                rs_credit,
    output logic                out_valid,
    output gnn_pkg::out_beat_t  out_beat,
    input  logic                out_credit
);
    import gnn_pkg::*;

    logic      acc_en;
    logic      cnt_step;
    logic      cnt_clear;
    logic      cnt_load;
    logic      buf_clr;
    logic      rs_send;
    logic      out_send;
    logic      rs_has_credit;
    logic      out_has_credit;
    logic      first_beat;
    logic      last_beat;
    beat_idx_t idx;
    node_id_t  node_id;
    fv_t       sum_lo;
    fv_t       sum_hi;
    rs_beat_t  rs_payload;
    out_beat_t out_payload;

    assign cnt_load = acc_en && in_beat.eos;                 // stream length known at eos.

    always_comb begin
        rs_payload.val_hi  = sum_hi;
        rs_payload.val_lo  = sum_lo;
        rs_payload.node_id = node_id;
        rs_payload.sos     = first_beat;
        rs_payload.eos     = last_beat;

        out_payload.val_hi  = sum_hi;
        out_payload.val_lo  = sum_lo;
        out_payload.node_id = node_id;
        out_payload.sos     = first_beat;
        out_payload.eos     = last_beat;
        out_payload.wb_tag  = 1'b1;
    end

    edge_bank_ctrl u_ctrl (
        .clk            (clk),
        .reset          (reset),
        .in_valid       (in_valid),
        .in_beat        (in_beat),
        .in_ready       (in_ready),
        .last_beat      (last_beat),
        .rs_has_credit  (rs_has_credit),
        .out_has_credit (out_has_credit),
        .acc_en         (acc_en),
        .cnt_step       (cnt_step),
        .cnt_clear      (cnt_clear),
        .buf_clr        (buf_clr),
        .rs_send        (rs_send),
        .out_send       (out_send),
        .node_id        (node_id)
    );

    beat_counter u_cnt (
        .clk        (clk),
        .reset      (reset),
        .step       (cnt_step),
        .clear      (cnt_clear),
        .load_len   (cnt_load),
        .idx        (idx),
        .first_beat (first_beat),
        .last_beat  (last_beat)
    );

    feature_accum_buffer u_buf (
        .clk    (clk),
        .reset  (reset),
        .acc_en (acc_en),
        .clr    (buf_clr),
        .idx    (idx),
        .add_lo (in_beat.val_lo),
        .add_hi (in_beat.val_hi),
        .sum_lo (sum_lo),
        .sum_hi (sum_hi)
    );

    credit_sender #(
        .payload_t (rs_beat_t),
        .CREDITS   (`RS_CREDITS)
    ) u_rs_send (
        .clk        (clk),
        .reset      (reset),
        .send       (rs_send),
        .payload    (rs_payload),
        .credit_in  (rs_credit),
        .has_credit (rs_has_credit),
        .valid      (rs_valid),
        .beat       (rs_beat)
    );

    credit_sender #(
        .payload_t (out_beat_t),
        .CREDITS   (`OUT_CREDITS)
    ) u_out_send (
        .clk        (clk),
        .reset      (reset),
        .send       (out_send),
        .payload    (out_payload),
        .credit_in  (out_credit),
        .has_credit (out_has_credit),
        .valid      (out_valid),
        .beat       (out_beat)
    );

endmodule

// File: tb_checker.sv
`timescale 1ns/100ps

module tb_checker (
    input logic               clk,
    input logic               reset,
    input logic               rs_valid,
    input gnn_pkg::rs_beat_t  rs_beat,
    input logic               out_valid,
    input gnn_pkg::out_beat_t out_beat
);
    import gnn_pkg::*;

    rs_beat_t  rs_q [$];
    out_beat_t out_q [$];
    int        errors = 0;
    int        checks = 0;
    int        tests = 0;
    int        rs_seen = 0;
    int        out_seen = 0;
    int        errors_before = 0;

    // rs beats are out beats without the trailing wb_tag bit.
    task automatic expect_beat(input bit to_out, input out_beat_t b);
        if (to_out) begin
            out_q.push_back(b);
        end else begin
            rs_q.push_back(b[$bits(out_beat_t)-1:1]);
        end
    endtask

    function automatic int pending();
        return rs_q.size() + out_q.size();
    endfunction

    task automatic check_field(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED %s: got 0x%0h, expected 0x%0h", name, got, exp);
        end
    endtask

    task automatic compare_beat(input string port, input out_beat_t got, input out_beat_t exp);
        check_field({port, ".val_lo"}, got.val_lo, exp.val_lo);
        check_field({port, ".val_hi"}, got.val_hi, exp.val_hi);
        check_field({port, ".node_id"}, got.node_id, exp.node_id);
        check_field({port, ".sos"}, got.sos, exp.sos);
        check_field({port, ".eos"}, got.eos, exp.eos);
        if (port == "out_beat") begin                       // rs beats carry no tag.
            check_field({port, ".wb_tag"}, got.wb_tag, exp.wb_tag);
        end
    endtask

    task automatic end_test(input string name);
        tests++;
        $display("test %0d %s: %0d errors", tests, name, errors - errors_before);
        errors_before = errors;
    endtask

    // outputs move just after the rising edge, so look on the falling one.
    always @(negedge clk) begin
        rs_beat_t  re;
        out_beat_t oe;
        if (reset && rs_valid) begin
            rs_seen++;
            if (rs_q.size() == 0) begin
                errors++;
                $display("a beat came out on the reservation station port with none expected");
            end else begin
                re = rs_q.pop_front();
                compare_beat("rs_beat", {rs_beat, 1'b0}, {re, 1'b0});
            end
        end
        if (reset && out_valid) begin
            out_seen++;
            if (out_q.size() == 0) begin
                errors++;
                $display("a beat came out on the output buffer port with none expected");
            end else begin
                oe = out_q.pop_front();
                compare_beat("out_beat", out_beat, oe);
            end
        end
    end

endmodule

// File: tb_edge_bank.sv
`timescale 1ns/100ps
`include "gnn_settings.svh"

module tb_edge_bank;
    import gnn_pkg::*;

    localparam int N_RAND      = 24;
    localparam int MAX_GAP     = 6;                         // credit return delay in cycles.
    localparam int WATCHDOG_NS = (N_RAND + 8) * BEATS * (MAX_GAP + 6) * 4 * 8;

    logic        clk = 1'b0;
    logic        reset;
    logic        in_valid;
    edge_beat_t  in_beat;
    logic        in_ready;
    logic        rs_valid;
    rs_beat_t    rs_beat;
    logic        rs_credit;
    logic        out_valid;
    out_beat_t   out_beat;
    logic        out_credit;
    logic [1:0]  credit = 2'b00;                            // bit 0 rs, bit 1 out.
    int          owed [2] = '{0, 0};
    int          gap [2] = '{0, 0};
    logic        hold_credits = 1'b0;
    logic [31:0] stim_seed = 32'hbdac_3e49;
    logic [31:0] credit_seed = ~32'hbdac_3e49;
    fv_t         ref_sums [`FV_NUM];

    assign rs_credit  = credit[0];
    assign out_credit = credit[1];

    edge_bank_top DUT (.*);

    tb_checker u_check (.clk, .reset, .rs_valid, .rs_beat, .out_valid, .out_beat);

    always #4 clk = ~clk;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic int draw(input int range);
        stim_seed = lcg_next(stim_seed);
        return int'(stim_seed[31:8] % range);
    endfunction

    // expected drain beat i from the running sums of the current node.
    function automatic out_beat_t model_beat(input int i, input int len, input node_id_t nid);
        return out_beat_t'{ref_sums[2*i+1], ref_sums[2*i], nid, i == 0, i == len - 1, 1'b1};
    endfunction

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    // cmd bit 0 is done_aggr, bit 1 is wb_en.
    task automatic run_stream(input node_id_t nid, input int len, input logic [1:0] cmd,
                              input bit gaps);
        fv_t lo [BEATS];
        fv_t hi [BEATS];
        for (int i = 0; i < len; i++) begin
            lo[i] = fv_t'(draw(32'h0100_0000));
            hi[i] = fv_t'(draw(32'h0100_0000));
            ref_sums[2*i]   = ref_sums[2*i] + lo[i];        // wraps at the feature width.
            ref_sums[2*i+1] = ref_sums[2*i+1] + hi[i];
        end
        if (cmd != 2'b00) begin
            for (int i = 0; i < len; i++) begin
                u_check.expect_beat(cmd == 2'b10, model_beat(i, len, nid));
            end
            ref_sums = '{default: '0};
        end
        for (int i = 0; i < len; i++) begin
            while (!in_ready || (gaps && draw(3) == 0)) begin
                next_cycle();
            end
            in_beat  = edge_beat_t'{hi[i], lo[i], nid, i == 0, i == len - 1,
                                    cmd[0] && (i == len - 1), cmd[1] && (i == len - 1)};
            in_valid = 1'b1;
            next_cycle();
            in_valid = 1'b0;
        end
    endtask

    task automatic wait_done();
        do begin
            next_cycle();
        end while (!in_ready || u_check.pending() != 0 || owed[0] != 0 || owed[1] != 0);
    endtask

    // one credit per beat seen, each after a random gap.
    always @(posedge clk) begin
        #1;
        for (int p = 0; p < 2; p++) begin
            owed[p]   = owed[p] + int'((p == 0) ? rs_valid : out_valid);
            credit[p] = 1'b0;
            if (gap[p] > 0) begin
                gap[p] = gap[p] - 1;
            end else if (owed[p] > 0 && !hold_credits) begin
                credit[p]   = 1'b1;
                owed[p]     = owed[p] - 1;
                credit_seed = lcg_next(credit_seed);
                gap[p]      = int'(credit_seed[31:8] % MAX_GAP);
            end
        end
    end

    initial begin
        int rs_mark;
        int out_mark;
        in_valid = 1'b0;
        in_beat  = '0;
        reset    = 1'b0;
        ref_sums = '{default: '0};
        repeat (16) @(posedge clk);
        #1;
        reset = 1'b1;
        u_check.check_field("in_ready", 32'(in_ready), 32'h1);
        u_check.check_field("rs_valid", 32'(rs_valid), 32'h0);
        u_check.check_field("out_valid", 32'(out_valid), 32'h0);

        run_stream(8'h21, BEATS, 2'b01, 1'b0);
        wait_done();
        u_check.end_test("full stream to rs");

        run_stream(8'h35, BEATS, 2'b00, 1'b0);
        run_stream(8'h35, BEATS, 2'b10, 1'b0);
        wait_done();
        u_check.end_test("two streams to out");

        run_stream(8'h4a, BEATS / 2 + 1, 2'b01, 1'b0);
        wait_done();
        u_check.end_test("clear after drain");

        hold_credits = 1'b1;
        rs_mark      = u_check.rs_seen;
        run_stream(8'h5c, BEATS, 2'b01, 1'b0);
        repeat (4 * BEATS + 8) next_cycle();
        u_check.check_field("rs_valid count", 32'(u_check.rs_seen - rs_mark),
                            32'((BEATS < `RS_CREDITS) ? BEATS : `RS_CREDITS));
        hold_credits = 1'b0;
        wait_done();
        u_check.end_test("credit stall");

        for (int t = 0; t < N_RAND; t++) begin
            run_stream(node_id_t'(draw(256)), 1 + draw(BEATS), 2'(draw(4)), 1'b1);
        end
        wait_done();
        u_check.end_test("random streams");

        rs_mark  = u_check.rs_seen;
        out_mark = u_check.out_seen;
        run_stream(8'h6e, BEATS, 2'b00, 1'b1);
        repeat (24) next_cycle();
        run_stream(8'h6e, BEATS - 1, 2'b01, 1'b1);
        wait_done();
        u_check.check_field("rs_valid count", 32'(u_check.rs_seen - rs_mark), 32'(BEATS - 1));
        u_check.check_field("out_valid count", 32'(u_check.out_seen - out_mark), 32'h0);
        u_check.end_test("unselected port quiet");

        $display("tests %0d, checks %0d, errors %0d", u_check.tests, u_check.checks,
                 u_check.errors);
        if (u_check.errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("timeout: the bank stopped making progress");
        $display("Some tests failed");
        $finish;
    end

endmodule

// File: sim.f
+incdir+.
gnn_pkg.sv
credit_sender.sv
beat_counter.sv
feature_accum_buffer.sv
edge_bank_ctrl.sv
edge_bank_top.sv
tb_checker.sv
tb_edge_bank.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal --top-module tb_edge_bank -f sim.f
out=$(./obj_dir/Vtb_edge_bank 2>&1) || true
echo "$out"
if echo "$out" | grep -qx "All tests passed"; then
    exit 0
fi
exit 1
